// ==== common/fp_pkg.sv ====
package fp_pkg;

  localparam int FE_BITS = 16;

  // base field element and the operand pair fed to every Fp unit
  typedef logic [FE_BITS-1:0] fe_t;

  typedef struct packed {
    fe_t hi; // b operand
    fe_t lo; // a operand
  } fe_pair_t;

  // P = 2^16 - 17, P mod 4 == 3 so i^2 + 1 is irreducible
  localparam fe_t FP_MOD = 16'd65519;

  // Barrett constants, mu = floor(2^34 / P)
  // quotient estimate is at most one short for any product below P^2
  localparam int BARRETT_K = 34;
  localparam logic [18:0] BARRETT_MU = 19'd262212;

endpackage

// ==== common/stream_pkg.sv ====
package stream_pkg;

  localparam int CTL_BITS = 8;

  // user tag, carried unchanged from request to result
  typedef logic [CTL_BITS-1:0] ctl_t;

  // unstalled depth of the Fp multiplier
  localparam int MUL_LAT = 4;

endpackage

// ==== common/if_fe_stream.sv ====
interface if_fe_stream
  import stream_pkg::*;
#(
  parameter type DAT_T = logic [31:0]
) ();

  DAT_T dat;
  logic val;
  logic rdy;
  logic sop; // first beat of a packet
  logic eop; // last beat of a packet
  ctl_t ctl;

  // a beat moves on a clock edge with val and rdy both high
  // source keeps everything steady while val is up and rdy is down
  modport source (
    output dat,
    output val,
    output sop,
    output eop,
    output ctl,
    input  rdy
  );

  modport sink (
    input  dat,
    input  val,
    input  sop,
    input  eop,
    input  ctl,
    output rdy
  );

endinterface

// ==== fp_mul/fp_mul_pipe.sv ====
module fp_mul_pipe
  import fp_pkg::*;
  import stream_pkg::*;
(
  input logic         i_clk,
  input logic         i_rst,
  if_fe_stream.sink   i_op_if,
  if_fe_stream.source o_res_if
);

  localparam int PROD_BITS = 2 * FE_BITS;
  localparam int MU_BITS   = $bits(BARRETT_MU);
  localparam int WIDE_BITS = PROD_BITS + MU_BITS;

  // framing and user tag, shifted alongside the data
  typedef struct packed {
    logic sop;
    logic eop;
    ctl_t ctl;
  } tag_t;

  logic                 en;
  logic [MUL_LAT-1:0]   vld;
  tag_t [MUL_LAT-1:0]   tag;
  tag_t                 in_tag;

  logic [PROD_BITS-1:0] s1_prod;  // a * b
  logic [WIDE_BITS-1:0] s1_wide;
  logic [PROD_BITS-1:0] s2_prod;
  logic [FE_BITS:0]     s2_quot;  // quotient estimate
  logic [PROD_BITS-1:0] s2_qp;
  logic [PROD_BITS-1:0] s2_diff;
  logic [FE_BITS:0]     s3_rem;   // below 2P
  logic [FE_BITS:0]     s3_red;
  fe_t                  res_q;

  // whole pipe freezes only while the result is held
  assign en          = ~o_res_if.val | o_res_if.rdy;
  assign i_op_if.rdy = en;

  assign in_tag = '{sop: i_op_if.sop, eop: i_op_if.eop, ctl: i_op_if.ctl};

  assign s1_wide = WIDE_BITS'(s1_prod) * WIDE_BITS'(BARRETT_MU);
  assign s2_qp   = PROD_BITS'(s2_quot) * PROD_BITS'(FP_MOD);
  assign s2_diff = s2_prod - s2_qp;
  assign s3_red  = (s3_rem >= {1'b0, FP_MOD}) ? s3_rem - {1'b0, FP_MOD} : s3_rem;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld <= '0;
      tag <= '0;
    end else if (en) begin
      vld <= {vld[MUL_LAT-2:0], i_op_if.val};
      tag <= {tag[MUL_LAT-2:0], in_tag};
    end
  end

  always_ff @(posedge i_clk) begin
    if (en) begin
      s1_prod <= PROD_BITS'(i_op_if.dat.lo) * PROD_BITS'(i_op_if.dat.hi);
      s2_prod <= s1_prod;
      s2_quot <= s1_wide[BARRETT_K +: FE_BITS+1]; // (x * mu) >> 34
      s3_rem  <= s2_diff[FE_BITS:0];              // x - q*P, upper bits are zero
      res_q   <= s3_red[FE_BITS-1:0];
    end
  end

  assign o_res_if.dat = res_q;
  assign o_res_if.val = vld[MUL_LAT-1];
  assign o_res_if.sop = tag[MUL_LAT-1].sop;
  assign o_res_if.eop = tag[MUL_LAT-1].eop;
  assign o_res_if.ctl = tag[MUL_LAT-1].ctl;

  // one correction step must be enough after the mu estimate
  a_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res_if.val |-> o_res_if.dat < FP_MOD);

endmodule

// ==== logic/fp_addsub.sv ====
module fp_addsub
  import fp_pkg::*;
#(
  parameter bit SUBTRACT = 1'b0 // 1: lo - hi, 0: lo + hi
) (
  input logic         i_clk,
  input logic         i_rst,
  if_fe_stream.sink   i_op_if,
  if_fe_stream.source o_res_if
);

  logic [FE_BITS:0] raw; // carry or borrow in the top bit
  fe_t              res;

  if (SUBTRACT) begin : g_sub
    always_comb begin
      raw = {1'b0, i_op_if.dat.lo} - {1'b0, i_op_if.dat.hi};
      // on borrow the low bits hold lo - hi + 2^16, adding P wraps back
      res = raw[FE_BITS] ? raw[FE_BITS-1:0] + FP_MOD : raw[FE_BITS-1:0];
    end
  end else begin : g_add
    always_comb begin
      raw = {1'b0, i_op_if.dat.lo} + {1'b0, i_op_if.dat.hi};
      if (raw >= {1'b0, FP_MOD})
        res = fe_t'(raw - {1'b0, FP_MOD});
      else
        res = raw[FE_BITS-1:0];
    end
  end

  // single output register, takes a new operand when empty or draining
  assign i_op_if.rdy = ~o_res_if.val | o_res_if.rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_if.val <= 1'b0;
      o_res_if.sop <= 1'b0;
      o_res_if.eop <= 1'b0;
    end else if (i_op_if.rdy) begin
      o_res_if.val <= i_op_if.val;
      o_res_if.dat <= res;
      o_res_if.ctl <= i_op_if.ctl;
      o_res_if.sop <= i_op_if.sop;
      o_res_if.eop <= i_op_if.eop;
    end
  end

  a_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    o_res_if.val |-> o_res_if.dat < FP_MOD);

endmodule

// ==== fe2_mul/fe2_mul_seq.sv ====
module fe2_mul_seq
  import fp_pkg::*;
(
  input logic         i_clk,
  input logic         i_rst,
  // Fp2 operand stream in, Fp2 result stream out
  if_fe_stream.sink   i_mul_fe2_if,
  if_fe_stream.source o_mul_fe2_if,
  // shared Fp multiplier
  if_fe_stream.source o_mul_fe_if,
  if_fe_stream.sink   i_mul_fe_if,
  // Fp subtractor, gives c0
  if_fe_stream.source o_sub_fe_if,
  if_fe_stream.sink   i_sub_fe_if,
  // Fp adder, gives c1
  if_fe_stream.source o_add_fe_if,
  if_fe_stream.sink   i_add_fe_if
);

  logic [1:0] mul_cnt; // issue slot: a0b0, a1b1, a1b0, a0b1
  logic [1:0] col_cnt; // which product comes back next
  logic       out_cnt; // 0 = c0 beat, 1 = c1 beat

  fe_t a_q;
  fe_t b_q;  // b0, later swapped for b1
  fe_t lo_q; // first product of each pair

  logic mul_free;
  logic sub_free;
  logic add_free;
  logic out_free;
  logic prod_xfer;

  // an output register can take new data when empty or draining this cycle
  assign mul_free = ~o_mul_fe_if.val | o_mul_fe_if.rdy;
  assign sub_free = ~o_sub_fe_if.val | o_sub_fe_if.rdy;
  assign add_free = ~o_add_fe_if.val | o_add_fe_if.rdy;
  assign out_free = ~o_mul_fe2_if.val | o_mul_fe2_if.rdy;

  // input beats only in the first two slots, cross products need no input
  assign i_mul_fe2_if.rdy = ~mul_cnt[1] & mul_free;

  always_comb begin
    case (col_cnt)
      2'd1:    i_mul_fe_if.rdy = sub_free; // second half of the sub pair
      2'd3:    i_mul_fe_if.rdy = add_free;
      default: i_mul_fe_if.rdy = 1'b1;     // goes to lo_q
    endcase
  end

  assign prod_xfer = i_mul_fe_if.val & i_mul_fe_if.rdy;

  assign i_sub_fe_if.rdy = ~out_cnt & out_free;
  assign i_add_fe_if.rdy = out_cnt & out_free;

  // issue to the multiplier
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mul_cnt         <= '0;
      o_mul_fe_if.val <= 1'b0;
      o_mul_fe_if.sop <= 1'b0;
      o_mul_fe_if.eop <= 1'b0;
    end else if (mul_free) begin
      case (mul_cnt)
        2'd0: begin
          o_mul_fe_if.dat <= i_mul_fe2_if.dat; // a0 * b0
          o_mul_fe_if.val <= i_mul_fe2_if.val;
          o_mul_fe_if.ctl <= i_mul_fe2_if.ctl;
          o_mul_fe_if.sop <= 1'b1;
          o_mul_fe_if.eop <= 1'b0;
          {b_q, a_q}      <= i_mul_fe2_if.dat;
          if (i_mul_fe2_if.val) mul_cnt <= 2'd1;
        end
        2'd1: begin
          o_mul_fe_if.dat <= i_mul_fe2_if.dat; // a1 * b1
          o_mul_fe_if.val <= i_mul_fe2_if.val;
          o_mul_fe_if.sop <= 1'b0;
          if (i_mul_fe2_if.val) mul_cnt <= 2'd2;
        end
        2'd2: begin
          // a1 stays in the lo half, b1 parked in b_q for the last slot
          o_mul_fe_if.dat <= {b_q, o_mul_fe_if.dat.lo};
          o_mul_fe_if.val <= 1'b1;
          b_q             <= o_mul_fe_if.dat.hi;
          mul_cnt         <= 2'd3;
        end
        default: begin
          o_mul_fe_if.dat <= {a_q, b_q}; // a0 * b1
          o_mul_fe_if.val <= 1'b1;
          o_mul_fe_if.eop <= 1'b1;
          mul_cnt         <= 2'd0;
        end
      endcase
    end
  end

  // pair up products for the sub and add units
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      col_cnt         <= '0;
      o_sub_fe_if.val <= 1'b0;
      o_sub_fe_if.sop <= 1'b0;
      o_sub_fe_if.eop <= 1'b0;
      o_add_fe_if.val <= 1'b0;
      o_add_fe_if.sop <= 1'b0;
      o_add_fe_if.eop <= 1'b0;
    end else begin
      if (o_sub_fe_if.val && o_sub_fe_if.rdy) o_sub_fe_if.val <= 1'b0;
      if (o_add_fe_if.val && o_add_fe_if.rdy) o_add_fe_if.val <= 1'b0;

      if (prod_xfer) begin
        col_cnt <= col_cnt + 2'd1;
        case (col_cnt)
          2'd1: begin
            // lo - hi = a0b0 - a1b1
            o_sub_fe_if.dat <= {i_mul_fe_if.dat, lo_q};
            o_sub_fe_if.ctl <= i_mul_fe_if.ctl;
            o_sub_fe_if.val <= 1'b1;
            o_sub_fe_if.sop <= 1'b1; // c0 opens the result
            o_sub_fe_if.eop <= 1'b0;
          end
          2'd3: begin
            o_add_fe_if.dat <= {i_mul_fe_if.dat, lo_q}; // a1b0 + a0b1
            o_add_fe_if.ctl <= i_mul_fe_if.ctl;
            o_add_fe_if.val <= 1'b1;
            o_add_fe_if.sop <= 1'b0;
            o_add_fe_if.eop <= 1'b1;
          end
          default: lo_q <= i_mul_fe_if.dat;
        endcase
      end
    end
  end

  // result stream, c0 from the subtractor then c1 from the adder
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      out_cnt          <= 1'b0;
      o_mul_fe2_if.val <= 1'b0;
      o_mul_fe2_if.sop <= 1'b0;
      o_mul_fe2_if.eop <= 1'b0;
    end else if (out_free) begin
      if (!out_cnt) begin
        o_mul_fe2_if.dat <= i_sub_fe_if.dat;
        o_mul_fe2_if.val <= i_sub_fe_if.val;
        o_mul_fe2_if.sop <= i_sub_fe_if.sop;
        o_mul_fe2_if.eop <= i_sub_fe_if.eop;
        o_mul_fe2_if.ctl <= i_sub_fe_if.ctl;
        if (i_sub_fe_if.val) out_cnt <= 1'b1;
      end else begin
        o_mul_fe2_if.dat <= i_add_fe_if.dat;
        o_mul_fe2_if.val <= i_add_fe_if.val;
        o_mul_fe2_if.sop <= i_add_fe_if.sop;
        o_mul_fe2_if.eop <= i_add_fe_if.eop;
        o_mul_fe2_if.ctl <= i_add_fe_if.ctl;
        if (i_add_fe_if.val) out_cnt <= 1'b0;
      end
    end
  end

  // operand beats have to line up with the issue slots
  a_in_frame: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_fe2_if.val && i_mul_fe2_if.rdy |->
      i_mul_fe2_if.sop == !mul_cnt[0] && i_mul_fe2_if.eop == mul_cnt[0]);

  // tags back from the multiplier keep issue and collect in step
  a_prod_frame: assert property (@(posedge i_clk) disable iff (i_rst)
    prod_xfer |->
      i_mul_fe_if.sop == (col_cnt == 2'd0) && i_mul_fe_if.eop == (col_cnt == 2'd3));

  // framing comes through the sub and add units, so check it here
  a_no_sop_eop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_fe2_if.val |-> !(o_mul_fe2_if.sop && o_mul_fe2_if.eop));

  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_mul_fe2_if.val && !o_mul_fe2_if.rdy |=>
      $stable(o_mul_fe2_if.dat) && $stable(o_mul_fe2_if.ctl));

endmodule

// ==== logic/fe2_mul_top.sv ====
module fe2_mul_top
  import fp_pkg::*;
  import stream_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  // operand stream, {b.c0, a.c0} then {b.c1, a.c1}
  input  fe_pair_t i_in_dat,
  input  logic     i_in_val,
  input  logic     i_in_sop,
  input  logic     i_in_eop,
  input  ctl_t     i_in_ctl,
  output logic     o_in_rdy,
  // result stream, c0 then c1
  output fe_t      o_out_dat,
  output logic     o_out_val,
  input  logic     i_out_rdy,
  output logic     o_out_sop,
  output logic     o_out_eop,
  output ctl_t     o_out_ctl
);

  if_fe_stream #(.DAT_T(fe_pair_t)) in_if ();
  if_fe_stream #(.DAT_T(fe_t))      out_if ();
  if_fe_stream #(.DAT_T(fe_pair_t)) seq2mul ();
  if_fe_stream #(.DAT_T(fe_t))      mul2seq ();
  if_fe_stream #(.DAT_T(fe_pair_t)) seq2sub ();
  if_fe_stream #(.DAT_T(fe_t))      sub2seq ();
  if_fe_stream #(.DAT_T(fe_pair_t)) seq2add ();
  if_fe_stream #(.DAT_T(fe_t))      add2seq ();

  assign in_if.dat = i_in_dat;
  assign in_if.val = i_in_val;
  assign in_if.sop = i_in_sop;
  assign in_if.eop = i_in_eop;
  assign in_if.ctl = i_in_ctl;
  assign o_in_rdy  = in_if.rdy;

  assign o_out_dat  = out_if.dat;
  assign o_out_val  = out_if.val;
  assign o_out_sop  = out_if.sop;
  assign o_out_eop  = out_if.eop;
  assign o_out_ctl  = out_if.ctl;
  assign out_if.rdy = i_out_rdy;

  fe2_mul_seq u_seq (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_mul_fe2_if (in_if),
    .o_mul_fe2_if (out_if),
    .o_mul_fe_if  (seq2mul),
    .i_mul_fe_if  (mul2seq),
    .o_sub_fe_if  (seq2sub),
    .i_sub_fe_if  (sub2seq),
    .o_add_fe_if  (seq2add),
    .i_add_fe_if  (add2seq)
  );

  fp_mul_pipe u_mul (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_op_if  (seq2mul),
    .o_res_if (mul2seq)
  );

  fp_addsub #(.SUBTRACT(1'b1)) u_sub (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_op_if  (seq2sub),
    .o_res_if (sub2seq)
  );

  fp_addsub #(.SUBTRACT(1'b0)) u_add (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_op_if  (seq2add),
    .o_res_if (add2seq)
  );

endmodule

// ==== tests/tb_fe2_mul.sv ====
module tb_fe2_mul
  import fp_pkg::*;
  import stream_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF    = 4;
  localparam int RST_CYCLES  = 10;
  localparam int IDLE_CYCLES = 20;
  localparam int N_ENT       = 20; // products in the stimulus file
  localparam int N_COL       = 7;  // a0 a1 b0 b1 ctl c0 c1
  localparam int PASSES      = 2;  // back to back first, then gaps and stalls
  localparam int N_RES       = N_ENT * PASSES;
  localparam int WD_CYCLES   = RST_CYCLES + 2 * IDLE_CYCLES
                               + 2 * N_RES * 4 * (MUL_LAT + 12);
  localparam logic [31:0] LFSR_SEED = 32'h98bdfbec;

  logic     clk;
  logic     rst;
  fe_pair_t in_dat;
  logic     in_val;
  logic     in_sop;
  logic     in_eop;
  ctl_t     in_ctl;
  logic     in_rdy;
  fe_t      out_dat;
  logic     out_val;
  logic     out_rdy;
  logic     out_sop;
  logic     out_eop;
  ctl_t     out_ctl;

  logic [15:0] stim [N_ENT*N_COL];
  logic [31:0] lfsr_q   = LFSR_SEED;
  int          in_cnt   = 0;    // operand beats taken by the DUT
  int          res_cnt  = 0;    // complete results checked
  logic        beat_c1  = 1'b0; // next output beat should be c1
  logic        held     = 1'b0;
  fe_t         held_dat;
  ctl_t        held_ctl;
  logic        held_sop;
  logic        held_eop;

  fe2_mul_top DUT (
    .i_clk     (clk),
    .i_rst     (rst),
    .i_in_dat  (in_dat),
    .i_in_val  (in_val),
    .i_in_sop  (in_sop),
    .i_in_eop  (in_eop),
    .i_in_ctl  (in_ctl),
    .o_in_rdy  (in_rdy),
    .o_out_dat (out_dat),
    .o_out_val (out_val),
    .i_out_rdy (out_rdy),
    .o_out_sop (out_sop),
    .o_out_eop (out_eop),
    .o_out_ctl (out_ctl)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b      = lfsr_q[0];
  endtask

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at %0d ns", $time);
  endtask

  task automatic check_fe(input string name, input fe_t got, input fe_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_ctl(input string name, input ctl_t got, input ctl_t exp);
    if (got !== exp)
      stop_run($sformatf("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // 0 half the time, else 1 to 4 idle cycles
  task automatic pick_gap(output int gap);
    logic b0;
    logic b1;
    logic b2;
    take_bit(b0);
    gap = 0;
    if (b0) begin
      take_bit(b1);
      take_bit(b2);
      gap = 1 + int'({b1, b2});
    end
  endtask

  // returns at the falling edge before the beat is taken
  task automatic send_beat(input fe_t a, input fe_t b, input ctl_t ctl, input logic last);
    in_dat = '{hi: b, lo: a};
    in_val = 1'b1;
    in_sop = ~last;
    in_eop = last;
    in_ctl = ctl;
    @(negedge clk);
    while (!in_rdy) @(negedge clk);
  endtask

  task automatic send_entry(input int e);
    ctl_t ctl;
    ctl = ctl_t'(stim[e*N_COL+4]);
    send_beat(stim[e*N_COL], stim[e*N_COL+2], ctl, 1'b0); // {b0, a0}
    @(posedge clk);
    #1;
    send_beat(stim[e*N_COL+1], stim[e*N_COL+3], ctl, 1'b1); // {b1, a1}
  endtask

  // one falling edge worth of output checks
  task automatic sample_output();
    int   e;
    fe_t  exp_dat;
    ctl_t exp_ctl;
    if (in_val && in_rdy) in_cnt++;
    if (out_val && in_cnt == 0)
      stop_run("o_out_val went high before any operand was taken");
    if (held) begin
      if (!out_val) stop_run("o_out_val dropped while the output was held");
      check_fe("o_out_dat", out_dat, held_dat);
      check_ctl("o_out_ctl", out_ctl, held_ctl);
      if (out_sop !== held_sop || out_eop !== held_eop)
        stop_run("o_out_sop or o_out_eop changed while the output was held");
    end
    held     = out_val && !out_rdy;
    held_dat = out_dat;
    held_ctl = out_ctl;
    held_sop = out_sop;
    held_eop = out_eop;
    if (out_val && out_rdy) begin
      e       = res_cnt % N_ENT;
      exp_ctl = ctl_t'(stim[e*N_COL+4]);
      exp_dat = beat_c1 ? stim[e*N_COL+6] : stim[e*N_COL+5];
      if (out_sop === beat_c1 || out_eop !== beat_c1)
        stop_run($sformatf("result %0d has wrong framing on its %s beat, sop %b eop %b",
                           res_cnt, beat_c1 ? "c1" : "c0", out_sop, out_eop));
      check_fe("o_out_dat", out_dat, exp_dat);
      check_ctl("o_out_ctl", out_ctl, exp_ctl);
      if (beat_c1) res_cnt++;
      beat_c1 = ~beat_c1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial begin : driver
    int gap;
    rst    = 1'b1;
    in_dat = '0;
    in_val = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_ctl = '0;
    $readmemh("tests/fe2_mul_stimulus.txt", stim);
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk); // DUT has to stay quiet here
    #1;
    for (int p = 0; p < PASSES; p++) begin
      for (int e = 0; e < N_ENT; e++) begin
        send_entry(e);
        gap = 0;
        if (p > 0) pick_gap(gap);
        @(posedge clk);
        #1;
        if (gap > 0) begin
          in_val = 1'b0;
          repeat (gap) @(posedge clk);
          #1;
        end
      end
    end
    in_val = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
  end

  // random stalls once the back to back pass has drained
  initial begin : rdy_gen
    logic b0;
    logic b1;
    out_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (res_cnt >= N_ENT) begin
        take_bit(b0);
        take_bit(b1);
        out_rdy = b0 | b1; // low about one cycle in four
      end
    end
  end

  initial begin : monitor
    repeat (RST_CYCLES) @(posedge clk);
    while (res_cnt < N_RES) begin
      @(negedge clk);
      sample_output();
    end
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      if (out_val) stop_run("o_out_val high with no operand left to answer");
    end
    $display("** PASS **");
    $finish;
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    stop_run($sformatf("results did not arrive within %0d cycles, %0d of %0d checked",
                       WD_CYCLES, res_cnt, N_RES));
  end

endmodule

// ==== tests/fe2_mul_stimulus.txt ====
// one Fp2 product per line, P = ffef
// a0 a1 b0 b1 ctl expected_c0 expected_c1 in hex
0000 0000 0000 0000 01 0000 0000
0001 0000 1234 5678 02 1234 5678
0000 0001 1234 5678 03 a977 1234
0000 0001 0000 0001 04 ffee 0000
ffee 0000 ffee 0000 05 0001 0000
ffee ffee ffee ffee 06 0000 0002
0002 0003 0004 0005 07 ffe8 0016
ffed ffec ffeb ffea 08 ffe8 0016
0001 0001 ffee ffee 09 0000 ffed
8000 8000 0002 0002 0a 0000 0022
8000 0000 8000 0000 0b 4044 0000
ffee 0001 0001 ffee 0c 0000 0002
03e8 07d0 0bb8 0fa0 0d afa3 a098
ffee 0002 0003 ffed 0e 0001 0008
0100 0100 0100 ff00 0f ef11 1100
ffee ffee ffee 0000 10 0001 0001
4000 c000 0004 0004 11 ffcd 0044
0003 ffec ffec 0003 12 0000 0012
1234 5678 0001 0000 13 1234 5678
0007 ffe8 0007 0007 14 0062 0000

// ==== fe2_mul.f ====
common/fp_pkg.sv
common/stream_pkg.sv
common/if_fe_stream.sv
fp_mul/fp_mul_pipe.sv
logic/fp_addsub.sv
fe2_mul/fe2_mul_seq.sv
logic/fe2_mul_top.sv
tests/tb_fe2_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the Fp2 multiplier testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module tb_fe2_mul \
  -Mdir obj_dir -f fe2_mul.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_fe2_mul
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
fi
exit "$status"
